//--- hdl/audio_pkg.sv
package audio_pkg;

	// audio widths
	localparam int PSG_W      = 8;	// one tone channel
	localparam int CHAN_SUM_W = 10;	// up to three tone channels summed
	localparam int DMA_W      = 8;	// dma sound sample
	localparam int MIX_W      = 15;	// tone + dma per side

	// midpoints of the unsigned sources
	localparam logic [CHAN_SUM_W-1:0] PSG_MID = 10'h200;
	localparam logic [DMA_W-1:0]      DMA_MID = 8'h80;

	typedef logic [PSG_W-1:0] psg_chan_t;

	typedef struct packed {
		psg_chan_t a;
		psg_chan_t b;
		psg_chan_t c;
	} ym_frame_t;

	// offset binary, 0x80 is silence
	typedef struct packed {
		logic [DMA_W-1:0] l;
		logic [DMA_W-1:0] r;
	} dma_frame_t;

	typedef struct packed {
		logic [CHAN_SUM_W-1:0] l;
		logic [CHAN_SUM_W-1:0] r;
	} psg_pair_t;

	typedef logic signed [MIX_W-1:0] mix_t;

	typedef struct packed {
		mix_t l;
		mix_t r;
	} mix_pair_t;

	// bit 2 stereo, bit 1 tone on, bit 0 dma on
	typedef struct packed {
		logic psg_stereo;
		logic psg_enable;
		logic dma_enable;
	} audio_cfg_t;

	localparam audio_cfg_t CFG_RESET = '{psg_stereo: 1'b0, psg_enable: 1'b1, dma_enable: 1'b1};

	// register map
	localparam int AXIL_AW = 4;
	localparam int AXIL_DW = 32;
	localparam logic [AXIL_AW-1:0] REG_CTRL = 4'h0;
	localparam logic [AXIL_AW-1:0] REG_ID   = 4'h4;
	localparam logic [7:0]         CORE_ID  = 8'hA7;	// same id the io controller sees

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// master side of the register port
	typedef struct packed {
		logic               awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic               wvalid;
		logic [AXIL_DW-1:0] wdata;
		logic [AXIL_DW/8-1:0] wstrb;
		logic               bready;
		logic               arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic               rready;
	} axil_req_t;

	typedef struct packed {
		logic               awready;
		logic               wready;
		logic               bvalid;
		logic [1:0]         bresp;
		logic               arready;
		logic               rvalid;
		logic [AXIL_DW-1:0] rdata;
		logic [1:0]         rresp;
	} axil_rsp_t;

endpackage

//--- hdl/audio_cfg_regs.sv
`timescale 1ns/10ps

module audio_cfg_regs (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  audio_pkg::axil_req_t   req_i,
	output audio_pkg::axil_rsp_t   rsp_o,
	output audio_pkg::audio_cfg_t  cfg_o
);

	audio_pkg::audio_cfg_t cfg_q;	// control register
	logic aw_w_rdy;			// awready and wready, always together
	logic wr_pend;			// write response outstanding
	logic rd_pend;			// read response outstanding
	logic wr_go;
	logic wr_hs;
	logic rd_go;
	logic rd_hit;
	logic [1:0] bresp_q;
	logic [1:0] rresp_q;
	logic [audio_pkg::AXIL_DW-1:0] rdata_q;
	logic [audio_pkg::AXIL_DW-1:0] rd_word;

	// both channels present and nothing waiting on bready
	assign wr_go = req_i.awvalid && req_i.wvalid && !wr_pend && !aw_w_rdy;
	assign wr_hs = aw_w_rdy && req_i.awvalid && req_i.wvalid;
	assign rd_go = req_i.arvalid && !rd_pend;	// ready follows valid

	// read decode
	always_comb begin
		rd_word = '0;
		rd_hit  = 1'b1;
		case (req_i.araddr)
			audio_pkg::REG_CTRL: rd_word[2:0] = cfg_q;
			audio_pkg::REG_ID:   rd_word[7:0] = audio_pkg::CORE_ID;
			default:             rd_hit = 1'b0;	// unmapped, reads zero
		endcase
	end

	// write path
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			aw_w_rdy <= 1'b0;
			wr_pend  <= 1'b0;
			cfg_q    <= audio_pkg::CFG_RESET;
		end else begin
			aw_w_rdy <= wr_go;	// one cycle pulse
			if (wr_hs) begin
				wr_pend <= 1'b1;
				// only the low byte carries control bits
				if (req_i.awaddr == audio_pkg::REG_CTRL && req_i.wstrb[0])
					cfg_q <= audio_pkg::audio_cfg_t'(req_i.wdata[2:0]);
			end else if (wr_pend && req_i.bready) begin
				wr_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_32) begin
		if (wr_hs)
			bresp_q <= (req_i.awaddr == audio_pkg::REG_CTRL) ?
				audio_pkg::RESP_OKAY : audio_pkg::RESP_SLVERR;
		if (rd_go) begin
			rdata_q <= rd_word;
			rresp_q <= rd_hit ? audio_pkg::RESP_OKAY : audio_pkg::RESP_SLVERR;
		end
	end

	// read path
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			rd_pend <= 1'b0;
		else if (rd_go)
			rd_pend <= 1'b1;
		else if (rd_pend && req_i.rready)
			rd_pend <= 1'b0;
	end

	assign rsp_o.awready = aw_w_rdy;
	assign rsp_o.wready  = aw_w_rdy;
	assign rsp_o.bvalid  = wr_pend;
	assign rsp_o.bresp   = bresp_q;
	assign rsp_o.arready = rd_go;
	assign rsp_o.rvalid  = rd_pend;
	assign rsp_o.rdata   = rdata_q;
	assign rsp_o.rresp   = rresp_q;

	assign cfg_o = cfg_q;

	// responses hold until taken
	a_b_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		rsp_o.bvalid && !req_i.bready |=> rsp_o.bvalid && $stable(rsp_o.bresp));
	a_r_hold: assert property (@(posedge clk_32) disable iff (!xsint)
		rsp_o.rvalid && !req_i.rready |=> rsp_o.rvalid && $stable(rsp_o.rdata));

endmodule

//--- hdl/psg_mixer.sv
`timescale 1ns/10ps

module psg_mixer (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  audio_pkg::ym_frame_t  ym_i,
	input  audio_pkg::audio_cfg_t cfg_i,
	output audio_pkg::psg_pair_t  psg_o
);

	localparam int EXT = audio_pkg::CHAN_SUM_W - audio_pkg::PSG_W;	// headroom bits

	logic [audio_pkg::CHAN_SUM_W-1:0] ch_a;
	logic [audio_pkg::CHAN_SUM_W-1:0] ch_b;
	logic [audio_pkg::CHAN_SUM_W-1:0] ch_c;
	logic [audio_pkg::CHAN_SUM_W-1:0] sum_ab;
	logic [audio_pkg::CHAN_SUM_W-1:0] sum_cb;
	logic [audio_pkg::CHAN_SUM_W-1:0] sum_abc;

	assign ch_a = {{EXT{1'b0}}, ym_i.a};
	assign ch_b = {{EXT{1'b0}}, ym_i.b};
	assign ch_c = {{EXT{1'b0}}, ym_i.c};

	assign sum_ab  = ch_a + ch_b;	// stereo left
	assign sum_cb  = ch_c + ch_b;	// stereo right, b in the middle
	assign sum_abc = sum_ab + ch_c;	// mono, max 3*255 fits

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			psg_o <= '0;
		end else if (!cfg_i.psg_enable) begin
			// midpoint cancels against the offset downstream
			psg_o.l <= audio_pkg::PSG_MID;
			psg_o.r <= audio_pkg::PSG_MID;
		end else if (cfg_i.psg_stereo) begin
			psg_o.l <= sum_ab;
			psg_o.r <= sum_cb;
		end else begin
			psg_o.l <= sum_abc;
			psg_o.r <= sum_abc;
		end
	end

endmodule

//--- hdl/sound_mixer.sv
`timescale 1ns/10ps

module sound_mixer (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  audio_pkg::psg_pair_t  psg_i,
	input  audio_pkg::dma_frame_t dma_i,
	input  audio_pkg::audio_cfg_t cfg_i,
	output audio_pkg::mix_pair_t  mix_o
);

	localparam int PT = audio_pkg::CHAN_SUM_W - 1;	// tone sign bit
	localparam int DT = audio_pkg::DMA_W - 1;	// dma sign bit

	audio_pkg::mix_t mix_l;
	audio_pkg::mix_t mix_r;

	// per side remove offsets, widen to 15 bits and add
	function automatic audio_pkg::mix_t mix_side(
		input logic [audio_pkg::CHAN_SUM_W-1:0] psg,
		input logic [audio_pkg::DMA_W-1:0]      dma,
		input logic                             dma_en
	);
		logic [audio_pkg::CHAN_SUM_W-1:0] psg_s;
		logic [audio_pkg::DMA_W-1:0]      dma_s;
		audio_pkg::mix_t                  psg_x;
		audio_pkg::mix_t                  dma_x;
		psg_s = psg - audio_pkg::PSG_MID;
		dma_s = dma_en ? dma - audio_pkg::DMA_MID : '0;	// muted dma adds nothing
		// top bits repeated below the lsb fill the range
		psg_x = {psg_s[PT], psg_s, psg_s[PT:PT-3]};
		dma_x = {dma_s[DT], dma_s, dma_s[DT:DT-5]};
		return psg_x + dma_x;
	endfunction

	assign mix_l = mix_side(psg_i.l, dma_i.l, cfg_i.dma_enable);
	assign mix_r = mix_side(psg_i.r, dma_i.r, cfg_i.dma_enable);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_o <= '0;
		end else begin
			mix_o.l <= mix_l;
			mix_o.r <= mix_r;
		end
	end

endmodule

//--- hdl/sigma_delta_dac.sv
`timescale 1ns/10ps

module sigma_delta_dac #(
	parameter int WIDTH = audio_pkg::MIX_W
) (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic signed [WIDTH-1:0] sample_i,
	output logic                    bit_o
);

	logic [WIDTH-1:0] acc_q;	// error accumulator
	logic [WIDTH-1:0] sample_ob;	// offset binary with 0 most negative
	logic [WIDTH:0]   sum;

	assign sample_ob = {~sample_i[WIDTH-1], sample_i[WIDTH-2:0]};
	assign sum = {1'b0, acc_q} + {1'b0, sample_ob};	// carry is the output bit

	// first order loop gives a ones density of sample_ob / 2**WIDTH
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_q <= '0;
			bit_o <= 1'b0;
		end else begin
			acc_q <= sum[WIDTH-1:0];
			bit_o <= sum[WIDTH];
		end
	end

endmodule

//--- hdl/audio_top.sv
`timescale 1ns/10ps

module audio_top (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  audio_pkg::ym_frame_t  ym_i,	// free running tone levels
	input  audio_pkg::dma_frame_t dma_i,	// free running dma sound
	input  audio_pkg::axil_req_t  cfg_req_i,
	output audio_pkg::axil_rsp_t  cfg_rsp_o,
	output logic                  audio_l_o,	// left bitstream
	output logic                  audio_r_o	// right bitstream
);

	audio_pkg::audio_cfg_t cfg;
	audio_pkg::psg_pair_t  psg;
	audio_pkg::mix_pair_t  mix;

	audio_cfg_regs cfg_regs (
		.clk_32 (clk_32),
		.xsint  (xsint),
		.req_i  (cfg_req_i),
		.rsp_o  (cfg_rsp_o),
		.cfg_o  (cfg)
	);

	psg_mixer psg_mix (
		.clk_32 (clk_32),
		.xsint  (xsint),
		.ym_i   (ym_i),
		.cfg_i  (cfg),
		.psg_o  (psg)	// one cycle after ym_i
	);

	sound_mixer snd_mix (
		.clk_32 (clk_32),
		.xsint  (xsint),
		.psg_i  (psg),
		.dma_i  (dma_i),
		.cfg_i  (cfg),
		.mix_o  (mix)	// one cycle after psg and dma_i
	);

	sigma_delta_dac #(.WIDTH(audio_pkg::MIX_W)) dac_l (
		.clk_32   (clk_32),
		.xsint    (xsint),
		.sample_i (mix.l),
		.bit_o    (audio_l_o)
	);

	sigma_delta_dac #(.WIDTH(audio_pkg::MIX_W)) dac_r (
		.clk_32   (clk_32),
		.xsint    (xsint),
		.sample_i (mix.r),
		.bit_o    (audio_r_o)
	);

endmodule

//--- tests/audio_checker.sv
`timescale 1ns/10ps

module audio_checker (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  audio_pkg::ym_frame_t  ym_i,
	input  audio_pkg::dma_frame_t dma_i,
	input  audio_pkg::axil_req_t  req_i,
	input  audio_pkg::axil_rsp_t  rsp_i,
	input  logic                  audio_l_i,
	input  logic                  audio_r_i
);

	localparam int N_WIN  = 4096;	// bitstream window
	localparam int SETTLE = 4;	// mixer pipe plus dac register

	int err_count = 0;
	int check_count = 0;
	string test_name = "reset";
	audio_pkg::audio_cfg_t cfg_m;	// control register as the bus saw it
	logic [31:0] exp_rdata;
	logic [1:0]  exp_rresp;
	logic [1:0]  exp_bresp;
	logic        stall_q;	// response held last cycle
	logic [31:0] stall_data;

	function automatic void begin_test(input string name);
		test_name = name;
	endfunction

	function automatic void compare(input string what, input int exp_v, input int act_v,
			input int tol);
		check_count++;
		if (exp_v - act_v > tol || act_v - exp_v > tol) begin
			err_count++;
			$display("mismatch %s %s expected %0d actual %0d", test_name, what, exp_v, act_v);
		end
	endfunction

	// one side as a signed 15 bit level
	function automatic int side_level(input int tone, input int smp, input logic dma_on);
		int t;
		int d;
		t = tone - 512;	// tone sum centred on 0x200
		d = dma_on ? smp - 128 : 0;
		// scaled up, low bits refilled from the value's own top bits
		return t * 16 + ((t & 'h3ff) >> 6) + d * 64 + ((d & 'hff) >> 2);
	endfunction

	function automatic int exp_ones(input int level);
		return (level + 16384) * N_WIN / 32768;	// offset binary density
	endfunction

	task automatic measure_window();
		int tl;
		int tr;
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		repeat (SETTLE) @(posedge clk_32);
		repeat (N_WIN) begin
			@(posedge clk_32);
			ones_l += int'(audio_l_i);
			ones_r += int'(audio_r_i);
		end
		// inputs were held for the whole window
		if (!cfg_m.psg_enable) begin
			tl = 512;
			tr = 512;
		end else if (cfg_m.psg_stereo) begin
			tl = int'(ym_i.a) + int'(ym_i.b);
			tr = int'(ym_i.c) + int'(ym_i.b);	// b sits in the middle
		end else begin
			tl = int'(ym_i.a) + int'(ym_i.b) + int'(ym_i.c);
			tr = tl;
		end
		compare("ones_l", exp_ones(side_level(tl, int'(dma_i.l), cfg_m.dma_enable)), ones_l, 1);
		compare("ones_r", exp_ones(side_level(tr, int'(dma_i.r), cfg_m.dma_enable)), ones_r, 1);
	endtask

	always @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			cfg_m   <= audio_pkg::CFG_RESET;
			stall_q <= 1'b0;
			if (clk_32 && (audio_l_i || audio_r_i || rsp_i.bvalid || rsp_i.rvalid)) begin
				err_count++;
				$display("%s: outputs active during reset", test_name);
			end
		end else begin
			if (req_i.arvalid && rsp_i.arready) begin	// answer taken from the model
				case (req_i.araddr)
					audio_pkg::REG_CTRL: begin
						exp_rdata <= {29'b0, cfg_m};
						exp_rresp <= audio_pkg::RESP_OKAY;
					end
					audio_pkg::REG_ID: begin
						exp_rdata <= {24'b0, audio_pkg::CORE_ID};
						exp_rresp <= audio_pkg::RESP_OKAY;
					end
					default: begin
						exp_rdata <= '0;
						exp_rresp <= audio_pkg::RESP_SLVERR;
					end
				endcase
			end
			if (req_i.awvalid && rsp_i.awready && req_i.wvalid && rsp_i.wready) begin
				exp_bresp <= (req_i.awaddr == audio_pkg::REG_CTRL) ?
					audio_pkg::RESP_OKAY : audio_pkg::RESP_SLVERR;
				if (req_i.awaddr == audio_pkg::REG_CTRL && req_i.wstrb[0])
					cfg_m <= audio_pkg::audio_cfg_t'(req_i.wdata[2:0]);
			end
			if (rsp_i.bvalid && req_i.bready)
				compare("bresp", int'(exp_bresp), int'(rsp_i.bresp), 0);
			if (rsp_i.rvalid && req_i.rready) begin
				compare("rdata", int'(exp_rdata), int'(rsp_i.rdata), 0);
				compare("rresp", int'(exp_rresp), int'(rsp_i.rresp), 0);
			end
			if (rsp_i.rvalid && rsp_i.arready) begin
				err_count++;
				$display("%s: a read was accepted while a response was pending", test_name);
			end
			if (stall_q && !(rsp_i.rvalid && rsp_i.rdata == stall_data)) begin
				err_count++;
				$display("%s: read response dropped or changed while stalled", test_name);
			end
			stall_q    <= rsp_i.rvalid && !req_i.rready;
			stall_data <= rsp_i.rdata;
		end
	end

endmodule

//--- tests/tb_audio_top.sv
`timescale 1ns/10ps

module tb_audio_top;

	localparam int CLK_NS  = 8;
	localparam int RST_CYC = 16;
	localparam int WIN_CYC = 4096 + 8;	// settle plus counting window
	localparam int N_WIN   = 11;	// 4 mono, 4 stereo, 3 muted
	localparam int AXI_CYC = 400;	// all register traffic, generous
	localparam int WD_NS   = (RST_CYC + N_WIN * WIN_CYC + AXI_CYC) * CLK_NS * 12 / 10;

	logic clk_32;
	logic xsint;
	audio_pkg::ym_frame_t  ym;
	audio_pkg::dma_frame_t dma;
	audio_pkg::axil_req_t  req;
	audio_pkg::axil_rsp_t  rsp;
	logic audio_l;
	logic audio_r;
	int unsigned stall;

	audio_top dut0 (.clk_32(clk_32), .xsint(xsint), .ym_i(ym), .dma_i(dma), .cfg_req_i(req),
		.cfg_rsp_o(rsp), .audio_l_o(audio_l), .audio_r_o(audio_r));

	audio_checker chk0 (.clk_32(clk_32), .xsint(xsint), .ym_i(ym), .dma_i(dma), .req_i(req),
		.rsp_i(rsp), .audio_l_i(audio_l), .audio_r_i(audio_r));

	initial begin
		clk_32 = 1'b0;
		forever #(CLK_NS / 2) clk_32 = ~clk_32;
	end

	initial begin
		#(WD_NS);
		$display("timeout: the run did not finish in %0d ns", WD_NS);
		$display("Test FAILED");
		$finish;
	end

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		@(negedge clk_32);
		req.awvalid = 1'b1;
		req.awaddr  = addr;
		req.wvalid  = 1'b1;
		req.wdata   = data;
		req.wstrb   = strb;
		while (!(rsp.awready && rsp.wready)) @(negedge clk_32);	// registered readies
		@(negedge clk_32);	// taken on the edge just passed
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		while (!rsp.bvalid) @(negedge clk_32);
		@(negedge clk_32);	// bready is always high here
	endtask

	task automatic axi_read(input logic [3:0] addr);
		@(negedge clk_32);
		req.arvalid = 1'b1;
		req.araddr  = addr;
		while (rsp.rvalid) @(negedge clk_32);	// arready waits for a free slot
		@(negedge clk_32);
		req.arvalid = 1'b0;
		while (!rsp.rvalid) @(negedge clk_32);
		@(negedge clk_32);
	endtask

	// first read held off by rready, second one queued behind it
	task automatic read_stalled(input int unsigned cycles);
		@(negedge clk_32);
		req.rready  = 1'b0;
		req.arvalid = 1'b1;
		req.araddr  = audio_pkg::REG_ID;
		while (!rsp.rvalid) @(negedge clk_32);
		req.araddr = audio_pkg::REG_CTRL;	// next request, arvalid stays up
		repeat (cycles) @(negedge clk_32);
		req.rready = 1'b1;
		@(negedge clk_32);
		while (rsp.rvalid) @(negedge clk_32);
		@(negedge clk_32);	// second read taken here
		req.arvalid = 1'b0;
		while (!rsp.rvalid) @(negedge clk_32);
		@(negedge clk_32);
	endtask

	task automatic play_random(input string name);
		@(negedge clk_32);
		ym.a  = 8'($urandom);
		ym.b  = 8'($urandom);
		ym.c  = 8'($urandom);
		dma.l = 8'($urandom);
		dma.r = 8'($urandom);
		chk0.begin_test(name);
		chk0.measure_window();	// settles, then counts ones
	endtask

	initial begin
		void'($urandom(32'hc91c1c66));
		xsint = 1'b0;
		ym    = '0;
		dma   = '{l: 8'h80, r: 8'h80};	// silence
		req   = '0;
		req.bready = 1'b1;
		req.rready = 1'b1;
		repeat (RST_CYC) @(negedge clk_32);
		xsint = 1'b1;

		chk0.begin_test("reset_values");
		axi_read(audio_pkg::REG_CTRL);
		axi_read(audio_pkg::REG_ID);

		chk0.begin_test("reg_access");
		repeat (4) begin
			axi_write(audio_pkg::REG_CTRL, $urandom, 4'hf);
			axi_read(audio_pkg::REG_CTRL);
		end
		axi_write(audio_pkg::REG_CTRL, $urandom, 4'he);	// low byte strobe off
		axi_write(4'h8, $urandom, 4'hf);	// unmapped
		axi_read(4'h8);
		axi_write(audio_pkg::REG_ID, $urandom, 4'hf);	// read only
		axi_read(audio_pkg::REG_ID);
		axi_read(4'hc);
		axi_read(audio_pkg::REG_CTRL);

		axi_write(audio_pkg::REG_CTRL, 32'h3, 4'h1);	// mono, both on
		repeat (4) play_random("mono");
		axi_write(audio_pkg::REG_CTRL, 32'h7, 4'h1);	// stereo, both on
		repeat (4) play_random("stereo");
		axi_write(audio_pkg::REG_CTRL, 32'h5, 4'h1);
		play_random("tone_mute");
		axi_write(audio_pkg::REG_CTRL, 32'h2, 4'h1);
		play_random("dma_mute");
		axi_write(audio_pkg::REG_CTRL, 32'h4, 4'h1);
		play_random("all_mute");

		chk0.begin_test("back_pressure");
		stall = 2 + $urandom % 12;
		read_stalled(stall);

		repeat (4) @(negedge clk_32);
		$display("errors: %0d in %0d checks", chk0.err_count, chk0.check_count);
		if (chk0.err_count == 0 && chk0.check_count > 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- audio_top.f
hdl/audio_pkg.sv
hdl/audio_cfg_regs.sv
hdl/psg_mixer.sv
hdl/sound_mixer.sv
hdl/sigma_delta_dac.sv
hdl/audio_top.sv
tests/audio_checker.sv
tests/tb_audio_top.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_audio_top \
	-f audio_top.f -o tb_audio_top
./obj_dir/tb_audio_top | tee sim.log

if grep -q "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
